/* sim.f */
+incdir+sim
hdl/runner_pkg.sv
hdl/frame_lfsr.sv
hdl/game_ctrl.sv
hdl/horizon_line.sv
hdl/runner_ground_top.sv
sim/tb_runner_ground.sv

/* Bender.yml */
package:
  name: runner_ground

sources:
  # Design, package first
  - files:
      - hdl/runner_pkg.sv
      - hdl/frame_lfsr.sv
      - hdl/game_ctrl.sv
      - hdl/horizon_line.sv
      - hdl/runner_ground_top.sv

  # Testbench, top module tb_runner_ground
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_runner_ground.sv

/* sim/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Common failure path of every check
task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Run stopped at the first error");
endtask

task automatic compare_state(input runner_pkg::game_state_t actual,
                             input runner_pkg::game_state_t expected,
                             input string                   what);
    if (actual !== expected) begin
        report_failure($sformatf("MISMATCH at %0t: %s expected %s got %s",
                                 $time, what, expected.name(), actual.name()));
    end
endtask

task automatic compare_speed(input runner_pkg::speed_t actual,
                             input runner_pkg::speed_t expected,
                             input string              what);
    if (actual !== expected) begin
        report_failure($sformatf("MISMATCH at %0t: %s expected %0d got %0d",
                                 $time, what, expected, actual));
    end
endtask

// Pixel positions print as signed values
task automatic compare_x_pos(input runner_pkg::x_pos_t actual,
                             input runner_pkg::x_pos_t expected,
                             input string              what);
    if (actual !== expected) begin
        report_failure($sformatf("MISMATCH at %0t: %s expected %0d got %0d",
                                 $time, what, expected, actual));
    end
endtask

task automatic compare_bit(input logic  actual,
                           input logic  expected,
                           input string what);
    if (actual !== expected) begin
        report_failure($sformatf("MISMATCH at %0t: %s expected %b got %b",
                                 $time, what, expected, actual));
    end
endtask

// Plain failure outside a value compare
task automatic require(input logic ok, input string what);
    if (!ok) begin
        report_failure(what);
    end
endtask

`endif

/* sim/tb_runner_ground.sv */
`timescale 1ns/1ps

module tb_runner_ground;

    localparam int WIDTH        = runner_pkg::DEF_WIDTH;
    localparam int SPEED_SCALE  = runner_pkg::DEF_SPEED_SCALE;
    localparam int INIT_SPEED   = 4096;
    localparam int ACCEL        = 512;
    localparam int MAX_SPEED    = 20480;
    localparam int FRAME_CYCLES = 8;     // Short frames for quick wraps

    localparam int SPAN         = WIDTH * SPEED_SCALE;  // Segment width in sub-pixels
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;

    // Frame budget of each test
    localparam int IDLE_FRAMES     = 4;
    localparam int SCROLL_FRAMES   = 10;
    localparam int WRAP_MAX_FRAMES = 1040;  // Sixteen wraps of each segment at full speed
    localparam int SAT_FRAMES      = 8;
    localparam int CRASH_FRAMES    = 5;
    localparam int TOTAL_FRAMES    = IDLE_FRAMES + SCROLL_FRAMES + WRAP_MAX_FRAMES
                                     + SAT_FRAMES + CRASH_FRAMES;
    localparam int TIMEOUT_CYCLES  = TOTAL_FRAMES * FRAME_CYCLES + RESET_CYCLES + 100;

    logic clk = 1'b0;
    logic rst;
    logic start;
    logic crash;

    runner_pkg::game_state_t game_state;
    runner_pkg::speed_t      speed;
    runner_pkg::x_pos_t      x_pos_a;
    runner_pkg::x_pos_t      x_pos_b;
    logic                    bump_a;
    logic                    bump_b;

    // Reference model of the game positions, speed and LFSR
    int          model_pos_a;
    int          model_pos_b;
    int          model_speed;
    logic [15:0] model_lfsr;
    logic        model_bump_a;
    logic        model_bump_b;
    int          bump_sets_a;   // Wraps that took a bump of one
    int          bump_sets_b;

    `include "tb_checks.svh"

    always #(CLK_PERIOD / 2) clk = ~clk;

    runner_ground_top #(
        .WIDTH       (WIDTH),
        .SPEED_SCALE (SPEED_SCALE),
        .INIT_SPEED  (INIT_SPEED),
        .ACCEL       (ACCEL),
        .MAX_SPEED   (MAX_SPEED),
        .FRAME_CYCLES(FRAME_CYCLES)
    ) uut (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .crash     (crash),
        .game_state(game_state),
        .speed     (speed),
        .x_pos_a   (x_pos_a),
        .x_pos_b   (x_pos_b),
        .bump_a    (bump_a),
        .bump_b    (bump_b)
    );

    task automatic reset_model();
        model_pos_a  = 0;
        model_pos_b  = SPAN;   // Second segment just off the right edge
        model_speed  = INIT_SPEED;
        model_lfsr   = 16'hACE1;
        model_bump_a = 1'b0;
        model_bump_b = 1'b0;
        bump_sets_a  = 0;
        bump_sets_b  = 0;
    endtask

    // Scroll with the old speed, then shift and ramp
    task automatic advance_model();
        logic feedback;
        model_pos_a = model_pos_a - model_speed;
        model_pos_b = model_pos_b - model_speed;
        if (model_pos_a <= -SPAN) begin
            model_pos_a  = model_pos_a + 2 * SPAN;
            model_bump_a = model_lfsr[0];  // Value before this frame's shift
            if (model_lfsr[0]) begin
                bump_sets_a++;
            end
        end
        if (model_pos_b <= -SPAN) begin
            model_pos_b  = model_pos_b + 2 * SPAN;
            model_bump_b = model_lfsr[0];
            if (model_lfsr[0]) begin
                bump_sets_b++;
            end
        end
        feedback    = model_lfsr[15] ^ model_lfsr[14] ^ model_lfsr[12] ^ model_lfsr[3];
        model_lfsr  = {model_lfsr[14:0], feedback};
        model_speed = (model_speed + ACCEL < MAX_SPEED) ? model_speed + ACCEL : MAX_SPEED;
    endtask

    task automatic check_outputs(input runner_pkg::game_state_t exp_state);
        compare_state(game_state, exp_state, "game_state");
        compare_speed(speed, runner_pkg::speed_t'(model_speed), "speed");
        compare_x_pos(x_pos_a, runner_pkg::x_pos_t'(model_pos_a / SPEED_SCALE), "x_pos_a");
        compare_x_pos(x_pos_b, runner_pkg::x_pos_t'(model_pos_b / SPEED_SCALE), "x_pos_b");
        compare_bit(bump_a, model_bump_a, "bump_a");
        compare_bit(bump_b, model_bump_b, "bump_b");
    endtask

    // Lands one cycle after each frame boundary
    task automatic step_frame();
        repeat (FRAME_CYCLES) @(negedge clk);
        advance_model();
        check_outputs(runner_pkg::RUNNING);
    endtask

    task automatic apply_reset();
        rst   = 1'b1;
        start = 1'b0;
        crash = 1'b0;
        reset_model();
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_outputs(runner_pkg::IDLE);
    endtask

    task automatic idle_hold();
        repeat (IDLE_FRAMES * FRAME_CYCLES) @(negedge clk);
        check_outputs(runner_pkg::IDLE);
    endtask

    task automatic scroll_and_ramp();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        compare_state(game_state, runner_pkg::RUNNING, "game_state after start");
        @(negedge clk);
        repeat (SCROLL_FRAMES) step_frame();
    endtask

    // Each segment must latch a one at some wrap so the bump path is seen
    task automatic wrap_segments();
        int frames;
        frames = 0;
        while ((bump_sets_a == 0 || bump_sets_b == 0) && frames < WRAP_MAX_FRAMES) begin
            step_frame();
            frames++;
        end
        require(bump_sets_a > 0, "Segment a never wrapped with a new bump of one");
        require(bump_sets_b > 0, "Segment b never wrapped with a new bump of one");
    endtask

    task automatic speed_saturation();
        repeat (SAT_FRAMES) begin
            step_frame();
            compare_speed(speed, runner_pkg::speed_t'(MAX_SPEED), "saturated speed");
        end
    endtask

    task automatic crash_freeze();
        crash = 1'b1;
        @(negedge clk);
        crash = 1'b0;
        check_outputs(runner_pkg::CRASHED);
        start = 1'b1;   // Must be ignored once crashed
        @(negedge clk);
        start = 1'b0;
        repeat (CRASH_FRAMES * FRAME_CYCLES) @(negedge clk);
        check_outputs(runner_pkg::CRASHED);
    endtask

    initial begin
        apply_reset();
        idle_hold();
        scroll_and_ramp();
        wrap_segments();
        speed_saturation();
        crash_freeze();
        $display("TEST RESULT: PASS");
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Watchdog expired");
    end

endmodule

/* hdl/runner_ground_top.sv */
`timescale 1ns/1ps

module runner_ground_top #(
    parameter int WIDTH        = runner_pkg::DEF_WIDTH,
    parameter int SPEED_SCALE  = runner_pkg::DEF_SPEED_SCALE,
    parameter int INIT_SPEED   = runner_pkg::DEF_INIT_SPEED,
    parameter int ACCEL        = runner_pkg::DEF_ACCEL,
    parameter int MAX_SPEED    = runner_pkg::DEF_MAX_SPEED,
    parameter int FRAME_CYCLES = runner_pkg::DEF_FRAME_CYCLES
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic                    crash,
    output runner_pkg::game_state_t game_state,
    output runner_pkg::speed_t      speed,
    output runner_pkg::x_pos_t      x_pos_a,
    output runner_pkg::x_pos_t      x_pos_b,
    output logic                    bump_a,
    output logic                    bump_b
);

    logic             update;    // Frame pulse
    runner_pkg::rng_t rng_data;

    game_ctrl #(
        .INIT_SPEED  (INIT_SPEED),
        .ACCEL       (ACCEL),
        .MAX_SPEED   (MAX_SPEED),
        .FRAME_CYCLES(FRAME_CYCLES)
    ) u_game_ctrl (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .crash     (crash),
        .game_state(game_state),
        .speed     (speed),
        .update    (update)
    );

    frame_lfsr u_frame_lfsr (
        .clk     (clk),
        .rst     (rst),
        .update  (update),
        .rng_data(rng_data)
    );

    // Start and crash go to both the controller and the scroller
    horizon_line #(
        .WIDTH      (WIDTH),
        .SPEED_SCALE(SPEED_SCALE)
    ) u_horizon_line (
        .clk     (clk),
        .rst     (rst),
        .update  (update),
        .speed   (speed),
        .start   (start),
        .crash   (crash),
        .rng_data(rng_data),
        .x_pos_a (x_pos_a),
        .x_pos_b (x_pos_b),
        .bump_a  (bump_a),
        .bump_b  (bump_b)
    );

endmodule

/* hdl/horizon_line.sv */
`timescale 1ns/1ps

// Two screen-wide ground segments that scroll left and swap sides
module horizon_line #(
    parameter int WIDTH       = runner_pkg::DEF_WIDTH,
    parameter int SPEED_SCALE = runner_pkg::DEF_SPEED_SCALE
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               update,
    input  runner_pkg::speed_t speed,
    input  logic               start,
    input  logic               crash,
    input  runner_pkg::rng_t   rng_data,
    output runner_pkg::x_pos_t x_pos_a,
    output runner_pkg::x_pos_t x_pos_b,
    output logic               bump_a,
    output logic               bump_b
);

    // Game position in sub-pixels
    typedef logic signed [20:0] game_pos_t;

    localparam game_pos_t          SPAN  = game_pos_t'(WIDTH * SPEED_SCALE);
    localparam game_pos_t          SCALE = game_pos_t'(SPEED_SCALE);
    localparam runner_pkg::x_pos_t X_FAR = runner_pkg::x_pos_t'(WIDTH);

    runner_pkg::line_state_t state;
    runner_pkg::line_state_t next_state;

    game_pos_t pos_a;
    game_pos_t pos_b;
    game_pos_t speed_s;
    game_pos_t step_a;
    game_pos_t step_b;
    game_pos_t new_a;
    game_pos_t new_b;
    logic      wrap_a;
    logic      wrap_b;
    logic      started;
    logic      advance;

    // Jump a segment that left the screen to the far side
    function automatic game_pos_t wrapped(game_pos_t pos, logic wrap);
        game_pos_t result;
        result = pos;
        if (wrap) begin
            result = pos + SPAN + SPAN;  // Two adds keep the sum in range
        end
        return result;
    endfunction

    // Signed divide truncates toward zero
    function automatic runner_pkg::x_pos_t to_pixel(game_pos_t pos);
        return runner_pkg::x_pos_t'(pos / SCALE);
    endfunction

    assign speed_s = game_pos_t'({1'b0, speed});

    always_comb begin
        step_a = pos_a - speed_s;
        step_b = pos_b - speed_s;
        wrap_a = step_a <= -SPAN;  // Fully off the left edge
        wrap_b = step_b <= -SPAN;
        new_a  = wrapped(step_a, wrap_a);
        new_b  = wrapped(step_b, wrap_b);
    end

    // Scroller FSM
    always_comb begin
        next_state = state;
        case (state)
            runner_pkg::LINE_WAITING: begin
                next_state = runner_pkg::LINE_RUNNING;
            end
            runner_pkg::LINE_RUNNING: begin
                if (update && started) begin
                    next_state = runner_pkg::LINE_UPDATING;
                end
            end
            runner_pkg::LINE_UPDATING: begin
                next_state = runner_pkg::LINE_RUNNING;
            end
            runner_pkg::LINE_CRASHED: begin
                next_state = runner_pkg::LINE_CRASHED;
            end
            default: begin
                next_state = runner_pkg::LINE_WAITING;
            end
        endcase
        if (crash) begin
            next_state = runner_pkg::LINE_CRASHED;  // Freeze on crash
        end
    end

    // Move on the same edge that samples update
    assign advance = (next_state == runner_pkg::LINE_UPDATING);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= runner_pkg::LINE_WAITING;
            started <= 1'b0;
            pos_a   <= '0;
            pos_b   <= SPAN;   // Second segment starts off the right edge
            x_pos_a <= '0;
            x_pos_b <= X_FAR;
            bump_a  <= 1'b0;
            bump_b  <= 1'b0;
        end else begin
            state <= next_state;
            if (start) begin
                started <= 1'b1;
            end
            if (advance) begin
                pos_a   <= new_a;
                pos_b   <= new_b;
                x_pos_a <= to_pixel(new_a);
                x_pos_b <= to_pixel(new_b);
                if (wrap_a) begin
                    bump_a <= rng_data[0];  // New bump type for the fresh segment
                end
                if (wrap_b) begin
                    bump_b <= rng_data[0];
                end
            end
        end
    end

endmodule

/* hdl/game_ctrl.sv */
`timescale 1ns/1ps

module game_ctrl #(
    parameter int INIT_SPEED   = runner_pkg::DEF_INIT_SPEED,
    parameter int ACCEL        = runner_pkg::DEF_ACCEL,
    parameter int MAX_SPEED    = runner_pkg::DEF_MAX_SPEED,
    parameter int FRAME_CYCLES = runner_pkg::DEF_FRAME_CYCLES
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic                    crash,
    output runner_pkg::game_state_t game_state,
    output runner_pkg::speed_t      speed,
    output logic                    update
);

    localparam int CNT_W = (FRAME_CYCLES > 1) ? $clog2(FRAME_CYCLES) : 1;

    localparam logic [CNT_W-1:0]   LAST_TICK = CNT_W'(FRAME_CYCLES - 1);
    localparam runner_pkg::speed_t SPEED_0   = runner_pkg::speed_t'(INIT_SPEED);
    localparam runner_pkg::speed_t SPEED_TOP = runner_pkg::speed_t'(MAX_SPEED);
    localparam logic [15:0]        ACCEL_W   = 16'(ACCEL);
    localparam logic [15:0]        MAX_W     = 16'(MAX_SPEED);

    runner_pkg::game_state_t next_state;
    logic [CNT_W-1:0]        tick_cnt;
    logic                    frame_done;
    logic [15:0]             speed_sum;   // One spare bit for the carry
    runner_pkg::speed_t      speed_next;

    // Game FSM
    always_comb begin
        next_state = game_state;
        case (game_state)
            runner_pkg::IDLE: begin
                if (start) begin
                    next_state = runner_pkg::RUNNING;
                end
            end
            runner_pkg::RUNNING: begin
                next_state = runner_pkg::RUNNING;
            end
            runner_pkg::CRASHED: begin
                next_state = runner_pkg::CRASHED;  // Held until rst
            end
            default: begin
                next_state = runner_pkg::IDLE;
            end
        endcase
        if (crash) begin
            next_state = runner_pkg::CRASHED;  // Crash wins over start
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            game_state <= runner_pkg::IDLE;
        end else begin
            game_state <= next_state;
        end
    end

    // Frame tick counter, sits at zero outside RUNNING
    assign frame_done = (game_state == runner_pkg::RUNNING) && (tick_cnt == LAST_TICK);

    always_ff @(posedge clk) begin
        if (rst) begin
            tick_cnt <= '0;
        end else if (game_state != runner_pkg::RUNNING || frame_done) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // Registered so the pulse lands FRAME_CYCLES after entry
    always_ff @(posedge clk) begin
        if (rst) begin
            update <= 1'b0;
        end else begin
            update <= frame_done && !crash;  // No frame once crashed
        end
    end

    // Speed ramp with saturation
    always_comb begin
        speed_sum = {1'b0, speed} + ACCEL_W;
        if (speed_sum >= MAX_W) begin
            speed_next = SPEED_TOP;
        end else begin
            speed_next = speed_sum[14:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            speed <= SPEED_0;
        end else if (update && !crash) begin
            speed <= speed_next;  // Horizon takes the old value on this edge
        end
    end

endmodule

/* hdl/frame_lfsr.sv */
`timescale 1ns/1ps

module frame_lfsr (
    input  logic             clk,
    input  logic             rst,
    input  logic             update,
    output runner_pkg::rng_t rng_data
);

    localparam logic [15:0] SEED = 16'hACE1;

    logic [15:0] lfsr;
    logic        feedback;

    // Taps 16, 15, 13 and 4, counted from one
    assign feedback = lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3];

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= SEED;
        end else if (update) begin
            lfsr <= {lfsr[14:0], feedback};  // One step per frame
        end
    end

    // Low bits only, reflects the earlier frames during an update
    assign rng_data = lfsr[10:0];

endmodule

/* hdl/runner_pkg.sv */
package runner_pkg;

    // Top level game flow
    typedef enum logic [1:0] {
        IDLE,
        RUNNING,
        CRASHED
    } game_state_t;

    // Horizon scroller FSM, prefixed to keep clear of the game states
    typedef enum logic [1:0] {
        LINE_WAITING,
        LINE_RUNNING,
        LINE_UPDATING,
        LINE_CRASHED
    } line_state_t;

    typedef logic [14:0]        speed_t;    // Sub-pixels per frame
    typedef logic signed [10:0] x_pos_t;    // On-screen pixel x
    typedef logic [10:0]        rng_t;      // Random data per frame

    localparam int DEF_WIDTH        = 640;    // Screen width in pixels
    localparam int DEF_SPEED_SCALE  = 1024;   // Sub-pixel steps per pixel
    localparam int DEF_INIT_SPEED   = 6144;   // Six pixels per frame
    localparam int DEF_ACCEL        = 1;
    localparam int DEF_MAX_SPEED    = 13312;  // Thirteen pixels per frame
    localparam int DEF_FRAME_CYCLES = 16;     // Clocks per frame

endpackage
